// ==== flist.f ====
hw/v06c_pkg.sv
hw/bus_status.sv
hw/io_decode.sv
hw/edisk_pager.sv
hw/joy_ports.sv
hw/covox_dac.sv
hw/v06c_glue.sv
test/v06c_glue_sva.sv
test/tb_v06c_glue.sv

// ==== Bender.yml ====
package:
  name: v06c_glue

sources:
  - hw/v06c_pkg.sv
  - hw/bus_status.sv
  - hw/io_decode.sv
  - hw/edisk_pager.sv
  - hw/joy_ports.sv
  - hw/covox_dac.sv
  - hw/v06c_glue.sv
  - target: test
    files:
      - test/v06c_glue_sva.sv
      - test/tb_v06c_glue.sv

// ==== test/tb_v06c_glue.sv ====
`timescale 1ns/10ps

module tb_v06c_glue;

	// Status bytes, bit 7 down: ram_read io_read m1 io_write halt_ack io_stack write_n int_ack
	localparam logic [7:0] ST_MEM_RD   = 8'h82;
	localparam logic [7:0] ST_MEM_WR   = 8'h00;
	localparam logic [7:0] ST_STACK_RD = 8'h86;
	localparam logic [7:0] ST_IO_RD    = 8'h42;
	localparam logic [7:0] ST_IO_WR    = 8'h10;
	localparam logic [7:0] ST_INT_ACK  = 8'h23;

	// Bus cycles per section, four clocks each
	localparam int BUS_COUNT   = 1 + 4 + 3 * (1 + 15) + 2 + 4 * (1 + 4 + 2 + 4) + 1;
	localparam int CYCLE_LIMIT = 2 * (2 + 4 * BUS_COUNT);

	logic        clk_sys;
	logic        cold_reset;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout;
	logic        cpu_sync;
	logic        cpu_dbin;
	logic        cpu_wr_n;
	logic [7:0]  joy_a;
	logic [7:0]  joy_b;
	logic [7:0]  cpu_din;
	logic [2:0]  ram_page;
	logic        mem_req;
	logic [15:0] audio;

	logic [7:0]  rd_data;
	logic [2:0]  rd_page;
	logic        rd_mreq;
	logic [31:0] rng;
	logic [1:0]  mode_sel;
	int          errors;
	int          sva_fails;
	int          cycles;

	logic [7:0]  edisk_vals [3] = '{8'hE1, 8'h36, 8'h13};
	logic [15:0] test_addrs [5] = '{16'h1234, 16'h8001, 16'hA5A5, 16'hC000, 16'hE7FF};
	logic [7:0]  mem_states [3] = '{ST_MEM_RD, ST_MEM_WR, ST_STACK_RD};

	v06c_glue #(
		.covox_lock_cycles (20)
	) i_v06c_glue (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.cpu_addr_i (cpu_addr),
		.cpu_dout_i (cpu_dout),
		.cpu_sync_i (cpu_sync),
		.cpu_dbin_i (cpu_dbin),
		.cpu_wr_n_i (cpu_wr_n),
		.joy_a_i    (joy_a),
		.joy_b_i    (joy_b),
		.cpu_din_o  (cpu_din),
		.ram_page_o (ram_page),
		.mem_req_o  (mem_req),
		.audio_o    (audio)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// --------------------------------------------------
	// Reference formats
	// --------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// Fire 2, fire 1, two zeros, down, up, left, right, active low
	function automatic logic [7:0] pad_format(input logic [7:0] pad);
		return ~{pad[5], pad[4], 2'b00, pad[2], pad[3], pad[1], pad[0]};
	endfunction

	// Up, right, down, left, fire 1, fire 2, two zeros
	function automatic logic [7:0] pu_format(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] o;
		o = a | b;
		return {o[3], o[0], o[2], o[1], o[4], o[5], 2'b00};
	endfunction

	function automatic logic [2:0] expect_page(input logic [7:0] r, input logic [15:0] a,
			input logic [7:0] st);
		logic acc;
		logic hit;
		acc = st[7] | ~st[1];
		// 8000 bank, A000 and C000 banks, E000 bank
		case (a[15:13])
			3'b100:  hit = r[6];
			3'b101,
			3'b110:  hit = 1'b1;
			3'b111:  hit = r[7];
			default: hit = 1'b0;
		endcase
		if (st[2] && r[4] && acc) begin
			return {1'b0, r[3:2]} + 3'd1;
		end else if (hit && acc && r[5]) begin
			return {1'b0, r[1:0]} + 3'd1;
		end
		return 3'd0;
	endfunction

	task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
		assert (act === exp) else begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// --------------------------------------------------
	// Bus stimulus
	// --------------------------------------------------
	task automatic next_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	// SYNC with status, then two data cycles, second one with data2
	task automatic bus_cycle(input logic [7:0] st, input logic [15:0] addr,
			input logic [7:0] data, input logic [7:0] data2);
		next_cycle();
		cpu_sync = 1'b1;
		cpu_dout = st;
		cpu_addr = addr;
		next_cycle();
		cpu_sync = 1'b0;
		cpu_dout = data;
		if (!st[1]) begin
			cpu_wr_n = 1'b0;
		end else begin
			cpu_dbin = 1'b1;
		end
		@(negedge clk_sys);
		rd_data = cpu_din;
		rd_page = ram_page;
		rd_mreq = mem_req;
		next_cycle();
		cpu_dout = data2;
		next_cycle();
		cpu_wr_n = 1'b1;
		cpu_dbin = 1'b0;
	endtask

	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		bus_cycle(ST_IO_WR, {8'h00, port}, data, data);
	endtask

	task automatic io_read(input logic [7:0] port);
		bus_cycle(ST_IO_RD, {8'h00, port}, 8'h00, 8'h00);
	endtask

	task automatic new_pads();
		rng = xorshift(rng);
		joy_a = rng[7:0];
		joy_b = rng[15:8];
	endtask

	task automatic read_joy(input logic [1:0] mode);
		logic [7:0] fa;
		logic [7:0] fb;
		logic [7:0] p_exp;
		fa = pad_format(joy_a);
		fb = pad_format(joy_b);
		case (mode)
			2'b00:   p_exp = fa & fb;
			2'b01:   p_exp = fa;
			2'b10:   p_exp = fb;
			default: p_exp = 8'hFF;
		endcase
		io_read(8'h06);
		check_value("joy P", p_exp, rd_data);
		io_read(8'h07);
		check_value("joy PU", pu_format(joy_a, joy_b), rd_data);
		io_read(8'h0E);
		check_value("joy A", fa, rd_data);
		io_read(8'h0F);
		check_value("joy B", fb, rd_data);
	endtask

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: test sequence still running after %0d cycles", cycles);
		$display("Verification failed");
		$finish;
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial begin
		cold_reset = 1'b1;
		cpu_addr   = '0;
		cpu_dout   = '0;
		cpu_sync   = 1'b0;
		cpu_dbin   = 1'b0;
		cpu_wr_n   = 1'b1;
		joy_a      = '0;
		joy_b      = '0;
		rng        = 32'hbbd6;
		mode_sel   = '0;
		errors     = 0;
		repeat (2) @(posedge clk_sys);
		#10;
		cold_reset = 1'b0;

		// Covox still locked
		io_write(8'h07, 8'h5A);
		check_value("covox locked", 16'h0000, audio);

		// Reset state and status decode
		bus_cycle(ST_MEM_RD, 16'hA000, 8'h00, 8'h00);
		check_value("reset page", 16'd0, rd_page);
		check_value("mem read req", 16'd1, rd_mreq);
		io_read(8'h10);
		check_value("edisk port read", 16'h00FF, rd_data);
		check_value("io read req", 16'd0, rd_mreq);
		// Joystick control port reads 00 outside an acknowledge
		bus_cycle(ST_INT_ACK, 16'h0004, 8'h00, 8'h00);
		check_value("int ack read", 16'h00FF, rd_data);
		io_write(8'h20, 8'h00);
		check_value("io write req", 16'd0, rd_mreq);

		foreach (edisk_vals[i]) begin
			io_write(8'h10, edisk_vals[i]);
			foreach (test_addrs[j]) begin
				foreach (mem_states[k]) begin
					bus_cycle(mem_states[k], test_addrs[j], 8'h00, 8'h00);
					check_value("edisk page",
						expect_page(edisk_vals[i], test_addrs[j], mem_states[k]), rd_page);
				end
			end
		end

		// Data changes in the second write cycle and must be ignored
		bus_cycle(ST_IO_WR, 16'h0010, 8'h20, 8'h23);
		bus_cycle(ST_MEM_RD, 16'hA000, 8'h00, 8'h00);
		check_value("edisk single write", expect_page(8'h20, 16'hA000, ST_MEM_RD), rd_page);

		// Each mode once by a full load and once by bit set/reset
		for (int m = 0; m < 4; m++) begin
			mode_sel = 2'(m);
			new_pads();
			io_write(8'h05, 8'h91 | {1'b0, mode_sel, 5'b00000});
			read_joy(mode_sel);
			new_pads();
			io_write(8'h04, 8'h0A | {7'b0000000, ~mode_sel[0]});
			io_write(8'h04, 8'h0C | {7'b0000000, ~mode_sel[1]});
			read_joy(~mode_sel);
		end

		io_write(8'h07, 8'hA5);
		check_value("covox sample", 16'h00A5 * 16'd64, audio);

		sva_fails = i_v06c_glue.i_v06c_glue_sva.fail_count;
		$display("Run complete: %0d check errors, %0d assertion failures", errors, sva_fails);
		if (errors == 0 && sva_fails == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== test/v06c_glue_sva.sv ====
`timescale 1ns/10ps

module v06c_glue_sva #(
	parameter int lock_cycles = v06c_pkg::COVOX_LOCK_DEFAULT
) (
	input logic                         clk_sys,
	input logic                         cold_reset,
	input logic [v06c_pkg::ADDR_W-1:0]  cpu_addr_i,
	input logic [v06c_pkg::DATA_W-1:0]  cpu_dout_i,
	input logic                         cpu_sync_i,
	input logic [v06c_pkg::DATA_W-1:0]  cpu_din_o,
	input logic [v06c_pkg::PAGE_W-1:0]  ram_page_o,
	input logic [v06c_pkg::AUDIO_W-1:0] audio_o,
	input v06c_pkg::status_word_u       status_i,
	input logic                         io_wr_i,
	input logic                         edisk_sel_i,
	input logic                         joy_sel_i,
	input logic                         vox_sel_i,
	input logic [v06c_pkg::JOY_W-1:0]   joy_p_i
);
	import v06c_pkg::*;

	int         fail_count = 0;
	int         lock_m;
	logic       io_wr_q;
	logic       first_wr;
	logic [7:0] edisk_m;
	logic [7:0] mode_m;
	logic [7:0] sample_m;

	task automatic report_fail(input string what);
		fail_count++;
		$error("Assertion on %s failed", what);
	endtask

	// --------------------------------------------------
	// Reference registers
	// --------------------------------------------------
	assign first_wr = io_wr_i & ~io_wr_q;

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			io_wr_q  <= 1'b0;
			edisk_m  <= '0;
			mode_m   <= '0;
			sample_m <= '0;
			lock_m   <= lock_cycles;
		end else begin
			io_wr_q <= io_wr_i;
			if (lock_m > 0) begin
				lock_m <= lock_m - 1;
			end
			if (first_wr && edisk_sel_i) begin
				edisk_m <= cpu_dout_i;
			end
			if (first_wr && vox_sel_i && lock_m == 0) begin
				sample_m <= cpu_dout_i;
			end
			if (first_wr && joy_sel_i && cpu_addr_i[0]) begin
				mode_m <= cpu_dout_i;
			end else if (first_wr && joy_sel_i && !cpu_dout_i[7]) begin
				mode_m[cpu_dout_i[3:1]] <= cpu_dout_i[0];
			end
		end
	end

	// --------------------------------------------------
	// Properties
	// --------------------------------------------------
	a_status: assert property (@(posedge clk_sys) disable iff (cold_reset)
		$rose(cpu_sync_i) |=> status_i.raw == $past(cpu_dout_i))
		else report_fail("status latch");

	// Nonzero page must come from the stack field or the window field
	a_page: assert property (@(posedge clk_sys) disable iff (cold_reset)
		ram_page_o != '0 |-> (edisk_m[4] && ram_page_o == edisk_m[3:2] + 3'd1)
			|| (edisk_m[5] && ram_page_o == edisk_m[1:0] + 3'd1))
		else report_fail("E-disk page");

	a_audio: assert property (@(posedge clk_sys) disable iff (cold_reset)
		audio_o == {2'b00, sample_m, 6'b000000})
		else report_fail("covox audio");

	a_joy_p: assert property (@(posedge clk_sys) disable iff (cold_reset)
		mode_m[6:5] == 2'b11 |-> joy_p_i == 8'hFF)
		else report_fail("joystick P idle");

	a_int_ack: assert property (@(posedge clk_sys) disable iff (cold_reset)
		status_i.flags.int_ack |-> cpu_din_o == IO_IDLE)
		else report_fail("interrupt acknowledge");

endmodule

bind v06c_glue v06c_glue_sva #(
	.lock_cycles (covox_lock_cycles)
) i_v06c_glue_sva (
	.*,
	.status_i    (status),
	.io_wr_i     (io_wr),
	.edisk_sel_i (edisk_sel),
	.joy_sel_i   (joy_sel),
	.vox_sel_i   (vox_sel),
	.joy_p_i     (joy_p)
);

// ==== hw/v06c_glue.sv ====
`timescale 1ns/10ps

module v06c_glue #(
	parameter int covox_lock_cycles = v06c_pkg::COVOX_LOCK_DEFAULT
) (
	input  logic                         clk_sys,
	input  logic                         cold_reset,
	input  logic [v06c_pkg::ADDR_W-1:0]  cpu_addr_i,
	input  logic [v06c_pkg::DATA_W-1:0]  cpu_dout_i,
	input  logic                         cpu_sync_i,
	input  logic                         cpu_dbin_i,
	input  logic                         cpu_wr_n_i,
	input  logic [v06c_pkg::JOY_W-1:0]   joy_a_i,
	input  logic [v06c_pkg::JOY_W-1:0]   joy_b_i,
	output logic [v06c_pkg::DATA_W-1:0]  cpu_din_o,
	output logic [v06c_pkg::PAGE_W-1:0]  ram_page_o,
	output logic                         mem_req_o,
	output logic [v06c_pkg::AUDIO_W-1:0] audio_o
);
	import v06c_pkg::*;

	status_word_u     status;
	logic             io_wr;
	logic             edisk_sel;
	logic             joy_sel;
	logic             vox_sel;
	logic [JOY_W-1:0] joy_p;
	logic [JOY_W-1:0] joy_pu;
	logic [JOY_W-1:0] joy_a_fmt;
	logic [JOY_W-1:0] joy_b_fmt;

	// --------------------------------------------------
	// CPU bus front end
	// --------------------------------------------------
	bus_status i_bus_status (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.cpu_sync_i (cpu_sync_i),
		.cpu_dout_i (cpu_dout_i),
		.cpu_dbin_i (cpu_dbin_i),
		.cpu_wr_n_i (cpu_wr_n_i),
		.status_o   (status),
		.io_rd_o    (),
		.io_wr_o    (io_wr),
		.mem_req_o  (mem_req_o)
	);

	io_decode i_io_decode (
		.cpu_addr_lo_i (cpu_addr_i[7:0]),
		.status_i      (status),
		.joy_p_i       (joy_p),
		.joy_pu_i      (joy_pu),
		.joy_a_fmt_i   (joy_a_fmt),
		.joy_b_fmt_i   (joy_b_fmt),
		.edisk_sel_o   (edisk_sel),
		.joy_sel_o     (joy_sel),
		.vox_sel_o     (vox_sel),
		.cpu_din_o     (cpu_din_o)
	);

	// --------------------------------------------------
	// Peripherals
	// --------------------------------------------------
	edisk_pager i_edisk_pager (
		.clk_sys       (clk_sys),
		.cold_reset    (cold_reset),
		.edisk_sel_i   (edisk_sel),
		.io_wr_i       (io_wr),
		.cpu_addr_hi_i (cpu_addr_i[ADDR_W-1 -: 3]),
		.cpu_dout_i    (cpu_dout_i),
		.status_i      (status),
		.ram_page_o    (ram_page_o)
	);

	joy_ports i_joy_ports (
		.clk_sys     (clk_sys),
		.cold_reset  (cold_reset),
		.joy_sel_i   (joy_sel),
		.io_wr_i     (io_wr),
		.cpu_addr0_i (cpu_addr_i[0]),
		.cpu_dout_i  (cpu_dout_i),
		.joy_a_i     (joy_a_i),
		.joy_b_i     (joy_b_i),
		.joy_p_o     (joy_p),
		.joy_pu_o    (joy_pu),
		.joy_a_fmt_o (joy_a_fmt),
		.joy_b_fmt_o (joy_b_fmt)
	);

	covox_dac #(
		.lock_cycles (covox_lock_cycles)
	) i_covox_dac (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.vox_sel_i  (vox_sel),
		.io_wr_i    (io_wr),
		.cpu_dout_i (cpu_dout_i),
		.audio_o    (audio_o)
	);

endmodule

// ==== hw/covox_dac.sv ====
`timescale 1ns/10ps

module covox_dac #(
	parameter int lock_cycles = v06c_pkg::COVOX_LOCK_DEFAULT
) (
	input  logic                         clk_sys,
	input  logic                         cold_reset,
	input  logic                         vox_sel_i,
	input  logic                         io_wr_i,
	input  logic [v06c_pkg::DATA_W-1:0]  cpu_dout_i,
	output logic [v06c_pkg::AUDIO_W-1:0] audio_o
);
	import v06c_pkg::*;

	localparam int CNT_W = (lock_cycles > 0) ? $clog2(lock_cycles + 1) : 1;

	logic [CNT_W-1:0]  lock_cnt;
	logic [DATA_W-1:0] sample_q;
	logic              we;
	logic              we_q;

	// Ignore stray writes while old software probes ports after boot
	assign we = io_wr_i & vox_sel_i & (lock_cnt == '0);

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			lock_cnt <= CNT_W'(lock_cycles);
			we_q     <= 1'b0;
			sample_q <= '0;
		end else begin
			if (lock_cnt != '0) begin
				lock_cnt <= lock_cnt - CNT_W'(1);
			end
			we_q <= we;
			if (we && !we_q) begin
				sample_q <= cpu_dout_i;
			end
		end
	end

	assign audio_o = AUDIO_W'(sample_q) << COVOX_SHIFT;

endmodule

// ==== hw/joy_ports.sv ====
`timescale 1ns/10ps

module joy_ports (
	input  logic                        clk_sys,
	input  logic                        cold_reset,
	input  logic                        joy_sel_i,
	input  logic                        io_wr_i,
	input  logic                        cpu_addr0_i,
	input  logic [v06c_pkg::DATA_W-1:0] cpu_dout_i,
	input  logic [v06c_pkg::JOY_W-1:0]  joy_a_i,
	input  logic [v06c_pkg::JOY_W-1:0]  joy_b_i,
	output logic [v06c_pkg::JOY_W-1:0]  joy_p_o,
	output logic [v06c_pkg::JOY_W-1:0]  joy_pu_o,
	output logic [v06c_pkg::JOY_W-1:0]  joy_a_fmt_o,
	output logic [v06c_pkg::JOY_W-1:0]  joy_b_fmt_o
);
	import v06c_pkg::*;

	logic [DATA_W-1:0] mode_q;
	logic              we;
	logic              we_q;
	logic [JOY_W-1:0]  pad_or;

	// Active-low pad layout of the A/B ports
	function automatic logic [JOY_W-1:0] pad_fmt(input logic [JOY_W-1:0] pad);
		pad_fmt = ~{pad[5], pad[4], 2'b00, pad[2], pad[3], pad[1], pad[0]};
	endfunction

	// --------------------------------------------------
	// Mode register
	// --------------------------------------------------
	assign we = io_wr_i & joy_sel_i;

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			we_q   <= 1'b0;
			mode_q <= '0;
		end else begin
			we_q <= we;
			if (we && !we_q) begin
				if (cpu_addr0_i) begin
					mode_q <= cpu_dout_i;
				end else if (!cpu_dout_i[7]) begin
					// Single bit set/reset, like a PPI port C command
					mode_q[cpu_dout_i[3:1]] <= cpu_dout_i[0];
				end
			end
		end
	end

	// --------------------------------------------------
	// Read formats
	// --------------------------------------------------
	assign joy_a_fmt_o = pad_fmt(joy_a_i);
	assign joy_b_fmt_o = pad_fmt(joy_b_i);

	assign pad_or   = joy_a_i | joy_b_i;
	assign joy_pu_o = {pad_or[3], pad_or[0], pad_or[2], pad_or[1], pad_or[4], pad_or[5], 2'b00};

	always_comb begin
		case (mode_q[6:5])
			2'b00:   joy_p_o = joy_a_fmt_o & joy_b_fmt_o;
			2'b01:   joy_p_o = joy_a_fmt_o;
			2'b10:   joy_p_o = joy_b_fmt_o;
			default: joy_p_o = '1;
		endcase
	end

endmodule

// ==== hw/edisk_pager.sv ====
`timescale 1ns/10ps

module edisk_pager (
	input  logic                         clk_sys,
	input  logic                         cold_reset,
	input  logic                         edisk_sel_i,
	input  logic                         io_wr_i,
	input  logic [2:0]                   cpu_addr_hi_i,
	input  logic [v06c_pkg::DATA_W-1:0]  cpu_dout_i,
	input  v06c_pkg::status_word_u       status_i,
	output logic [v06c_pkg::PAGE_W-1:0]  ram_page_o
);
	import v06c_pkg::*;

	logic [DATA_W-1:0] edisk_q;
	logic              we;
	logic              we_q;
	logic              win_hit;
	logic              access;
	logic              stack_hit;
	logic              ram_hit;

	// --------------------------------------------------
	// Control register, one write per I/O cycle
	// --------------------------------------------------
	assign we = io_wr_i & edisk_sel_i;

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			we_q    <= 1'b0;
			edisk_q <= '0;
		end else begin
			we_q <= we;
			if (we && !we_q) begin
				edisk_q <= cpu_dout_i;
			end
		end
	end

	// --------------------------------------------------
	// Page selection
	// --------------------------------------------------
	// Window is A000-DFFF, plus 8000 and E000 banks when enabled
	assign win_hit = cpu_addr_hi_i[2]
		& ((cpu_addr_hi_i[1] ^ cpu_addr_hi_i[0])
		| (edisk_q[7] & cpu_addr_hi_i[1] & cpu_addr_hi_i[0])
		| (edisk_q[6] & ~cpu_addr_hi_i[1] & ~cpu_addr_hi_i[0]));

	assign access    = status_i.flags.ram_read | ~status_i.flags.write_n;
	assign stack_hit = edisk_q[4] & status_i.flags.io_stack & access;
	assign ram_hit   = edisk_q[5] & win_hit & access;

	// Page 0 is main RAM, E-disk banks start at 1
	always_comb begin
		if (stack_hit) begin
			ram_page_o = {1'b0, edisk_q[3:2]} + PAGE_W'(1);
		end else if (ram_hit) begin
			ram_page_o = {1'b0, edisk_q[1:0]} + PAGE_W'(1);
		end else begin
			ram_page_o = '0;
		end
	end

endmodule

// ==== hw/io_decode.sv ====
`timescale 1ns/10ps

module io_decode (
	input  logic [7:0]                  cpu_addr_lo_i,
	input  v06c_pkg::status_word_u      status_i,
	input  logic [v06c_pkg::JOY_W-1:0]  joy_p_i,
	input  logic [v06c_pkg::JOY_W-1:0]  joy_pu_i,
	input  logic [v06c_pkg::JOY_W-1:0]  joy_a_fmt_i,
	input  logic [v06c_pkg::JOY_W-1:0]  joy_b_fmt_i,
	output logic                        edisk_sel_o,
	output logic                        joy_sel_o,
	output logic                        vox_sel_o,
	output logic [v06c_pkg::DATA_W-1:0] cpu_din_o
);
	import v06c_pkg::*;

	// --------------------------------------------------
	// Write selects
	// --------------------------------------------------
	// Joystick control occupies the even/odd pair
	assign joy_sel_o   = (cpu_addr_lo_i[7:1] == PORT_JOY_BASE[7:1]);
	assign vox_sel_o   = (cpu_addr_lo_i == PORT_VOX);
	assign edisk_sel_o = (cpu_addr_lo_i == PORT_EDISK);

	// --------------------------------------------------
	// Read data back to the CPU
	// --------------------------------------------------
	always_comb begin
		cpu_din_o = IO_IDLE;
		if (status_i.flags.int_ack) begin
			// Acknowledge reads RST 7 from the floating bus
			cpu_din_o = IO_IDLE;
		end else if (joy_sel_o) begin
			cpu_din_o = '0;
		end else begin
			case (cpu_addr_lo_i)
				PORT_JOY_P: cpu_din_o = joy_p_i;
				PORT_VOX:   cpu_din_o = joy_pu_i;
				PORT_JOY_A: cpu_din_o = joy_a_fmt_i;
				PORT_JOY_B: cpu_din_o = joy_b_fmt_i;
				default:    cpu_din_o = IO_IDLE;
			endcase
		end
	end

endmodule

// ==== hw/bus_status.sv ====
`timescale 1ns/10ps

module bus_status (
	input  logic                          clk_sys,
	input  logic                          cold_reset,
	input  logic                          cpu_sync_i,
	input  logic [v06c_pkg::DATA_W-1:0]   cpu_dout_i,
	input  logic                          cpu_dbin_i,
	input  logic                          cpu_wr_n_i,
	output v06c_pkg::status_word_u        status_o,
	output logic                          io_rd_o,
	output logic                          io_wr_o,
	output logic                          mem_req_o
);
	import v06c_pkg::*;

	logic sync_q;

	// Status byte is on the data bus while SYNC is high
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			sync_q       <= 1'b0;
			status_o.raw <= STATUS_RESET;
		end else begin
			sync_q <= cpu_sync_i;
			if (cpu_sync_i && !sync_q) begin
				status_o.raw <= cpu_dout_i;
			end
		end
	end

	// Access qualifiers
	assign io_rd_o = status_o.flags.io_read & cpu_dbin_i;
	assign io_wr_o = status_o.flags.io_write & ~cpu_wr_n_i;

	// Memory cycle, read or write, but not an I/O cycle
	assign mem_req_o = (status_o.flags.ram_read | ~status_o.flags.write_n)
		& ~status_o.flags.io_read & ~status_o.flags.io_write;

endmodule

// ==== hw/v06c_pkg.sv ====
package v06c_pkg;

	// --------------------------------------------------
	// Bus and datapath widths
	// --------------------------------------------------
	localparam int ADDR_W  = 16;
	localparam int DATA_W  = 8;
	localparam int PAGE_W  = 3;
	localparam int AUDIO_W = 16;
	localparam int JOY_W   = 8;

	// Port numbers on the low address byte
	localparam logic [7:0] PORT_JOY_BASE = 8'h04;
	localparam logic [7:0] PORT_JOY_P    = 8'h06;
	localparam logic [7:0] PORT_VOX      = 8'h07;
	localparam logic [7:0] PORT_JOY_A    = 8'h0E;
	localparam logic [7:0] PORT_JOY_B    = 8'h0F;
	localparam logic [7:0] PORT_EDISK    = 8'h10;

	// Floating bus value
	localparam logic [7:0] IO_IDLE = 8'hFF;

	// Idle status after reset, write_n high and nothing else set
	localparam logic [7:0] STATUS_RESET = 8'h02;

	// Covox scaling and lock-out length
	localparam int COVOX_SHIFT        = 6;
	localparam int COVOX_LOCK_DEFAULT = 200_000_000;

	// --------------------------------------------------
	// 8080 status word
	// --------------------------------------------------
	typedef struct packed {
		logic ram_read;
		logic io_read;
		logic m1;
		logic io_write;
		logic halt_ack;
		logic io_stack;
		logic write_n;
		logic int_ack;
	} status_flags_t;

	typedef union packed {
		logic [DATA_W-1:0] raw;
		status_flags_t     flags;
	} status_word_u;

endpackage
